//--- verilog/mmul_defs.svh
/*
 * Matrix-multiply accelerator build constants:
 * memory port count, event lines, peripheral ID width
 * and the register map of the configuration block.
 */

`ifndef MMUL_DEFS_SVH
`define MMUL_DEFS_SVH

`define MMUL_MP          2      // 32-bit memory ports
`define MMUL_N_CORES     8      // event lines, one per core
`define MMUL_ID_W        8      // peripheral request id width

// register offsets within the peripheral window
`define MMUL_REG_TRIGGER 8'h00
`define MMUL_REG_STATUS  8'h04
`define MMUL_REG_X_ADDR  8'h08
`define MMUL_REG_W_ADDR  8'h0C
`define MMUL_REG_Z_ADDR  8'h10
`define MMUL_REG_M       8'h14
`define MMUL_REG_N       8'h18
`define MMUL_REG_K       8'h1C

`endif

//--- verilog/mmul_pkg.sv
/*
 * Matrix-multiply accelerator types: matrix elements,
 * lane accumulators, addresses, dimensions, wide memory
 * beats and the controller state encoding.
 */

`include "mmul_defs.svh"

package mmul_pkg;

  localparam int unsigned LANES = 2 * `MMUL_MP; // 16-bit elements per beat

  typedef logic signed [15:0]       elem_t;
  typedef logic signed [31:0]       acc_t;
  typedef logic [31:0]              addr_t;   // byte address
  typedef logic [15:0]              dim_t;
  typedef logic [32*`MMUL_MP-1:0]   beat_t;   // lane 0 in the low bits
  typedef logic [$clog2(LANES)-1:0] lane_t;

  typedef enum logic [2:0] {
    st_idle,
    st_load_x,
    st_wait_x,
    st_load_w,
    st_wait_w,
    st_store,
    st_done
  } ctrl_state_e;

endpackage

//--- verilog/mmul_regfile.sv
/*
 * Configuration register block on the peripheral slave port.
 * Holds matrix bases and dimensions, returns status and
 * raises the start pulse on a TRIGGER write while idle.
 */

`timescale 1ns/1ps
`include "mmul_defs.svh"

module mmul_regfile (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  periph_req_i,
  input  mmul_pkg::addr_t       periph_add_i,
  input  logic                  periph_wen_i,     // 1 reads
  input  logic [3:0]            periph_be_i,
  input  logic [31:0]           periph_data_i,
  input  logic [`MMUL_ID_W-1:0] periph_id_i,
  output logic                  periph_gnt_o,
  output logic [31:0]           periph_r_data_o,
  output logic                  periph_r_valid_o,
  output logic [`MMUL_ID_W-1:0] periph_r_id_o,
  input  logic                  busy_i,
  output logic                  start_o,
  output mmul_pkg::addr_t       x_addr_o,
  output mmul_pkg::addr_t       w_addr_o,
  output mmul_pkg::addr_t       z_addr_o,
  output mmul_pkg::dim_t        m_o,
  output mmul_pkg::dim_t        n_o,
  output mmul_pkg::dim_t        k_o
);
  import mmul_pkg::*;

  logic [7:0]            offset;
  logic                  wr_en;
  logic                  rd_en;
  logic [31:0]           rd_data;
  logic                  r_valid_q;
  logic [31:0]           r_data_q;
  logic [`MMUL_ID_W-1:0] r_id_q;
  addr_t                 x_addr_q;
  addr_t                 w_addr_q;
  addr_t                 z_addr_q;
  dim_t                  m_q;
  dim_t                  n_q;
  dim_t                  k_q;

  // replace only the enabled bytes of a register
  function automatic logic [31:0] be_merge(input logic [31:0] old_v,
                                           input logic [31:0] new_v,
                                           input logic [3:0]  be);
    logic [31:0] res;
    res = old_v;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[8*b +: 8] = new_v[8*b +: 8];
    end
    return res;
  endfunction

  assign periph_gnt_o = periph_req_i;      // never stalls
  assign offset       = periph_add_i[7:0];
  assign wr_en        = periph_req_i & ~periph_wen_i & ~busy_i; // writes dropped while running
  assign rd_en        = periph_req_i & periph_wen_i;
  assign start_o      = wr_en & (offset == `MMUL_REG_TRIGGER);

  always_comb begin
    case (offset)
      `MMUL_REG_STATUS: rd_data = {31'd0, busy_i};
      `MMUL_REG_X_ADDR: rd_data = x_addr_q;
      `MMUL_REG_W_ADDR: rd_data = w_addr_q;
      `MMUL_REG_Z_ADDR: rd_data = z_addr_q;
      `MMUL_REG_M:      rd_data = {16'd0, m_q};
      `MMUL_REG_N:      rd_data = {16'd0, n_q};
      `MMUL_REG_K:      rd_data = {16'd0, k_q};
      default:          rd_data = '0;         // trigger and unmapped
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      x_addr_q  <= '0;
      w_addr_q  <= '0;
      z_addr_q  <= '0;
      m_q       <= '0;
      n_q       <= '0;
      k_q       <= '0;
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= periph_req_i;             // one response per granted access
      if (wr_en) begin
        case (offset)
          `MMUL_REG_X_ADDR: x_addr_q <= be_merge(x_addr_q, periph_data_i, periph_be_i);
          `MMUL_REG_W_ADDR: w_addr_q <= be_merge(w_addr_q, periph_data_i, periph_be_i);
          `MMUL_REG_Z_ADDR: z_addr_q <= be_merge(z_addr_q, periph_data_i, periph_be_i);
          `MMUL_REG_M: m_q <= dim_t'(be_merge({16'd0, m_q}, periph_data_i, periph_be_i));
          `MMUL_REG_N: n_q <= dim_t'(be_merge({16'd0, n_q}, periph_data_i, periph_be_i));
          `MMUL_REG_K: k_q <= dim_t'(be_merge({16'd0, k_q}, periph_data_i, periph_be_i));
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (periph_req_i) begin
      r_id_q   <= periph_id_i;
      r_data_q <= rd_en ? rd_data : '0;    // writes answer with zero data
    end
  end

  assign periph_r_valid_o = r_valid_q;
  assign periph_r_data_o  = r_data_q;
  assign periph_r_id_o    = r_id_q;
  assign x_addr_o         = x_addr_q;
  assign w_addr_o         = w_addr_q;
  assign z_addr_o         = z_addr_q;
  assign m_o              = m_q;
  assign n_o              = n_q;
  assign k_o              = k_q;

endmodule

//--- verilog/mmul_ctrl.sv
/*
 * Matrix-multiply sequencer. Walks rows, column blocks of
 * LANES outputs and the reduction index, issuing one X read
 * and one W read per step and one store per row chunk.
 */

`timescale 1ns/1ps
`include "mmul_defs.svh"

module mmul_ctrl (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    start_i,
  input  mmul_pkg::addr_t         x_addr_i,
  input  mmul_pkg::addr_t         w_addr_i,
  input  mmul_pkg::addr_t         z_addr_i,
  input  mmul_pkg::dim_t          m_i,
  input  mmul_pkg::dim_t          n_i,
  input  mmul_pkg::dim_t          k_i,
  output logic                    busy_o,
  output logic [`MMUL_N_CORES-1:0] evt_o,
  output logic                    mem_req_o,
  output logic                    mem_wen_o,
  output mmul_pkg::addr_t         mem_addr_o,
  input  logic                    mem_gnt_i,
  input  logic                    mem_rvalid_i,
  output logic                    acc_clear_o,
  output logic                    x_load_o,
  output logic                    w_step_o,
  output mmul_pkg::lane_t         x_sel_o
);
  import mmul_pkg::*;

  localparam addr_t BEAT_MASK = ~addr_t'(4 * `MMUL_MP - 1);
  localparam dim_t  LANES_D   = dim_t'(LANES);

  ctrl_state_e state_q;
  dim_t        row_q;
  dim_t        col_q;
  dim_t        step_q;
  addr_t       x_row_q;   // element offset of X row start
  addr_t       x_off_q;   // element offset of current X operand
  addr_t       w_off_q;   // element offset of current W beat
  addr_t       z_off_q;   // element offset of current Z chunk
  addr_t       x_byte;
  logic        launch;
  logic        last_step;
  logic        last_col;
  logic        last_row;

  assign x_byte    = x_addr_i + (x_off_q << 1);
  assign launch    = start_i & ((state_q == st_idle) | (state_q == st_done));
  assign last_step = (step_q == dim_t'(n_i - 1'b1));
  assign last_col  = (dim_t'(col_q + LANES_D) == k_i);
  assign last_row  = (row_q == dim_t'(m_i - 1'b1));

  assign busy_o      = (state_q != st_idle) & (state_q != st_done);
  assign evt_o       = {`MMUL_N_CORES{state_q == st_done}};
  assign acc_clear_o = launch | ((state_q == st_store) & mem_gnt_i);
  assign x_load_o    = (state_q == st_wait_x) & mem_rvalid_i;
  assign w_step_o    = (state_q == st_wait_w) & mem_rvalid_i;
  assign x_sel_o     = x_off_q[$clog2(LANES)-1:0];    // element slot in the beat

  always_comb begin
    mem_req_o  = 1'b0;
    mem_wen_o  = 1'b1;
    mem_addr_o = '0;
    case (state_q)
      st_load_x: begin
        mem_req_o  = 1'b1;
        mem_addr_o = x_byte & BEAT_MASK;
      end
      st_load_w: begin
        mem_req_o  = 1'b1;
        mem_addr_o = w_addr_i + (w_off_q << 1);
      end
      st_store: begin
        mem_req_o  = 1'b1;
        mem_wen_o  = 1'b0;
        mem_addr_o = z_addr_i + (z_off_q << 1);
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= st_idle;
      row_q   <= '0;
      col_q   <= '0;
      step_q  <= '0;
      x_row_q <= '0;
      x_off_q <= '0;
      w_off_q <= '0;
      z_off_q <= '0;
    end else begin
      case (state_q)
        st_idle, st_done: begin
          if (launch) begin
            row_q   <= '0;
            col_q   <= '0;
            step_q  <= '0;
            x_row_q <= '0;
            x_off_q <= '0;
            w_off_q <= '0;
            z_off_q <= '0;
            state_q <= st_load_x;
          end else begin
            state_q <= st_idle;
          end
        end
        st_load_x: if (mem_gnt_i) state_q <= st_wait_x;
        st_wait_x: if (mem_rvalid_i) state_q <= st_load_w;
        st_load_w: if (mem_gnt_i) state_q <= st_wait_w;
        st_wait_w: begin
          if (mem_rvalid_i) begin
            x_off_q <= x_off_q + 1'b1;
            w_off_q <= w_off_q + addr_t'(k_i);   // next W row, same columns
            if (last_step) begin
              step_q  <= '0;
              state_q <= st_store;
            end else begin
              step_q  <= step_q + 1'b1;
              state_q <= st_load_x;
            end
          end
        end
        st_store: begin
          if (mem_gnt_i) begin
            z_off_q <= z_off_q + addr_t'(LANES);
            if (last_col) begin
              col_q   <= '0;
              w_off_q <= '0;
              x_row_q <= x_row_q + addr_t'(n_i);
              x_off_q <= x_row_q + addr_t'(n_i);
              row_q   <= row_q + 1'b1;
              state_q <= last_row ? st_done : st_load_x;
            end else begin
              col_q   <= col_q + LANES_D;
              w_off_q <= addr_t'(col_q + LANES_D);
              x_off_q <= x_row_q;              // rewalk the same X row
              state_q <= st_load_x;
            end
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

endmodule

//--- verilog/mmul_streamer.sv
/*
 * Wide memory access splitter. Fans one beat out over MP
 * word ports at consecutive addresses and joins grants,
 * read valids and read data back into one wide access.
 */

`timescale 1ns/1ps
`include "mmul_defs.svh"

module mmul_streamer (
  input  logic                          mem_req_i,
  input  logic                          mem_wen_i,
  input  mmul_pkg::addr_t               mem_addr_i,
  input  mmul_pkg::beat_t               mem_wdata_i,
  output logic                          mem_gnt_o,
  output logic                          mem_rvalid_o,
  output mmul_pkg::beat_t               mem_rdata_o,
  output logic [`MMUL_MP-1:0]           tcdm_req_o,
  output logic [`MMUL_MP-1:0]           tcdm_wen_o,
  output logic [`MMUL_MP-1:0][31:0]     tcdm_add_o,
  output logic [`MMUL_MP-1:0][3:0]      tcdm_be_o,
  output logic [`MMUL_MP-1:0][31:0]     tcdm_data_o,
  input  logic [`MMUL_MP-1:0]           tcdm_gnt_i,
  input  logic [`MMUL_MP-1:0]           tcdm_r_valid_i,
  input  logic [`MMUL_MP-1:0][31:0]     tcdm_r_data_i
);
  import mmul_pkg::*;

  for (genvar ii = 0; ii < `MMUL_MP; ii++) begin : g_port
    assign tcdm_req_o[ii]  = mem_req_i;
    assign tcdm_wen_o[ii]  = mem_wen_i;
    assign tcdm_add_o[ii]  = mem_addr_i + addr_t'(4 * ii);   // word ii of the beat
    assign tcdm_be_o[ii]   = 4'hF;
    assign tcdm_data_o[ii] = mem_wdata_i[32*ii +: 32];
  end

  // all ports must accept and answer together
  assign mem_gnt_o    = &tcdm_gnt_i;
  assign mem_rvalid_o = &tcdm_r_valid_i;
  assign mem_rdata_o  = beat_t'(tcdm_r_data_i);   // port 0 lands in the low word

endmodule

//--- verilog/mmul_datapath.sv
/*
 * Multiply-accumulate datapath. Captures one X element as a
 * scalar and accumulates its product with LANES W elements,
 * packing the low 16 bits of each lane into the result beat.
 */

`timescale 1ns/1ps
`include "mmul_defs.svh"

module mmul_datapath (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic            acc_clear_i,
  input  logic            x_load_i,
  input  logic            w_step_i,
  input  mmul_pkg::lane_t x_sel_i,
  input  mmul_pkg::beat_t rdata_i,
  output mmul_pkg::beat_t result_o
);
  import mmul_pkg::*;

  elem_t x_q;   // scalar operand of the current step

  always_ff @(posedge clk_i) begin
    if (x_load_i) x_q <= rdata_i[16*x_sel_i +: 16];
  end

  for (genvar l = 0; l < LANES; l++) begin : g_lane
    elem_t w_elem;
    acc_t  prod;
    acc_t  acc_q;

    assign w_elem = rdata_i[16*l +: 16];
    assign prod   = x_q * w_elem;         // full signed product

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        acc_q <= '0;
      end else if (acc_clear_i) begin
        acc_q <= '0;
      end else if (w_step_i) begin
        acc_q <= acc_q + prod;
      end
    end

    assign result_o[16*l +: 16] = acc_q[15:0];   // wraps to the element width
  end

endmodule

//--- verilog/mmul_wrap.sv
/*
 * Matrix-multiply accelerator top level. Connects the
 * configuration block, sequencer, port splitter and MAC
 * datapath to the peripheral slave and memory master ports.
 */

`timescale 1ns/1ps
`include "mmul_defs.svh"

module mmul_wrap (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  output logic [`MMUL_N_CORES-1:0]  evt_o,
  output logic                      busy_o,
  output logic [`MMUL_MP-1:0]       tcdm_req_o,
  input  logic [`MMUL_MP-1:0]       tcdm_gnt_i,
  output logic [`MMUL_MP-1:0][31:0] tcdm_add_o,
  output logic [`MMUL_MP-1:0]       tcdm_wen_o,
  output logic [`MMUL_MP-1:0][3:0]  tcdm_be_o,
  output logic [`MMUL_MP-1:0][31:0] tcdm_data_o,
  input  logic [`MMUL_MP-1:0][31:0] tcdm_r_data_i,
  input  logic [`MMUL_MP-1:0]       tcdm_r_valid_i,
  input  logic                      periph_req_i,
  output logic                      periph_gnt_o,
  input  mmul_pkg::addr_t           periph_add_i,
  input  logic                      periph_wen_i,
  input  logic [3:0]                periph_be_i,
  input  logic [31:0]               periph_data_i,
  input  logic [`MMUL_ID_W-1:0]     periph_id_i,
  output logic [31:0]               periph_r_data_o,
  output logic                      periph_r_valid_o,
  output logic [`MMUL_ID_W-1:0]     periph_r_id_o
);
  import mmul_pkg::*;

  logic  start;
  addr_t x_addr;
  addr_t w_addr;
  addr_t z_addr;
  dim_t  m_dim;
  dim_t  n_dim;
  dim_t  k_dim;
  logic  mem_req;
  logic  mem_wen;
  addr_t mem_addr;
  logic  mem_gnt;
  logic  mem_rvalid;
  beat_t mem_rdata;
  beat_t result;
  logic  acc_clear;
  logic  x_load;
  logic  w_step;
  lane_t x_sel;

  mmul_regfile i_regfile (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .periph_req_i     (periph_req_i),
    .periph_add_i     (periph_add_i),
    .periph_wen_i     (periph_wen_i),
    .periph_be_i      (periph_be_i),
    .periph_data_i    (periph_data_i),
    .periph_id_i      (periph_id_i),
    .periph_gnt_o     (periph_gnt_o),
    .periph_r_data_o  (periph_r_data_o),
    .periph_r_valid_o (periph_r_valid_o),
    .periph_r_id_o    (periph_r_id_o),
    .busy_i           (busy_o),
    .start_o          (start),
    .x_addr_o         (x_addr),
    .w_addr_o         (w_addr),
    .z_addr_o         (z_addr),
    .m_o              (m_dim),
    .n_o              (n_dim),
    .k_o              (k_dim)
  );

  mmul_ctrl i_ctrl (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .start_i      (start),
    .x_addr_i     (x_addr),
    .w_addr_i     (w_addr),
    .z_addr_i     (z_addr),
    .m_i          (m_dim),
    .n_i          (n_dim),
    .k_i          (k_dim),
    .busy_o       (busy_o),
    .evt_o        (evt_o),
    .mem_req_o    (mem_req),
    .mem_wen_o    (mem_wen),
    .mem_addr_o   (mem_addr),
    .mem_gnt_i    (mem_gnt),
    .mem_rvalid_i (mem_rvalid),
    .acc_clear_o  (acc_clear),
    .x_load_o     (x_load),
    .w_step_o     (w_step),
    .x_sel_o      (x_sel)
  );

  mmul_streamer i_streamer (
    .mem_req_i      (mem_req),
    .mem_wen_i      (mem_wen),
    .mem_addr_i     (mem_addr),
    .mem_wdata_i    (result),
    .mem_gnt_o      (mem_gnt),
    .mem_rvalid_o   (mem_rvalid),
    .mem_rdata_o    (mem_rdata),
    .tcdm_req_o     (tcdm_req_o),
    .tcdm_wen_o     (tcdm_wen_o),
    .tcdm_add_o     (tcdm_add_o),
    .tcdm_be_o      (tcdm_be_o),
    .tcdm_data_o    (tcdm_data_o),
    .tcdm_gnt_i     (tcdm_gnt_i),
    .tcdm_r_valid_i (tcdm_r_valid_i),
    .tcdm_r_data_i  (tcdm_r_data_i)
  );

  mmul_datapath i_datapath (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .acc_clear_i (acc_clear),
    .x_load_i    (x_load),
    .w_step_i    (w_step),
    .x_sel_i     (x_sel),
    .rdata_i     (mem_rdata),
    .result_o    (result)
  );

endmodule

//--- test/tb_mmul.sv
/*
 * Testbench for the matrix-multiply accelerator. Models a banked
 * word memory with optional random grant stalls, programs the
 * register block and checks results, events and status.
 */

`timescale 1ns/1ps
`include "mmul_defs.svh"

module tb_mmul;
  import mmul_pkg::*;

  localparam int MP    = `MMUL_MP;
  localparam int DEPTH = 128;                  // words per bank

  logic                      clk_i = 1'b0;
  logic                      arst_n_i;
  logic [`MMUL_N_CORES-1:0]  evt_o;
  logic                      busy_o;
  logic [MP-1:0]             tcdm_req_o;
  logic [MP-1:0]             tcdm_gnt_i;
  logic [MP-1:0][31:0]       tcdm_add_o;
  logic [MP-1:0]             tcdm_wen_o;
  logic [MP-1:0][3:0]        tcdm_be_o;
  logic [MP-1:0][31:0]       tcdm_data_o;
  logic [MP-1:0][31:0]       tcdm_r_data_i;
  logic [MP-1:0]             tcdm_r_valid_i;
  logic                      periph_req_i;
  logic                      periph_gnt_o;
  logic [31:0]               periph_add_i;
  logic                      periph_wen_i;
  logic [3:0]                periph_be_i;
  logic [31:0]               periph_data_i;
  logic [`MMUL_ID_W-1:0]     periph_id_i;
  logic [31:0]               periph_r_data_o;
  logic                      periph_r_valid_o;
  logic [`MMUL_ID_W-1:0]     periph_r_id_o;

  logic [31:0]           bank_mem [MP][DEPTH];
  logic                  stall_en;
  logic                  busy_prev = 1'b0;
  logic [`MMUL_ID_W-1:0] next_id;
  int                    err_cnt = 0;
  int                    evt_cnt = 0;
  int                    n_pass = 0;
  int                    n_fail = 0;
  int                    wd_cycles = 0;
  int                    t_m[$];
  int                    t_n[$];
  int                    t_k[$];
  int                    t_stall[$];
  int                    t_base[$];
  logic [31:0]           t_xa[$];
  logic [31:0]           t_wa[$];
  logic [31:0]           t_za[$];
  logic [15:0]           vals[$];                // X, W and expected Z of all tests

  always #5 clk_i = ~clk_i;

  mmul_wrap UUT (.*);

  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("FAIL at %0t ns: %s is %h, expected %h", $time, sig, got, exp);
    err_cnt++;
  endtask

  task automatic report_problem(input string what);
    $display("ERROR at %0t ns: %s", $time, what);
    err_cnt++;
  endtask

  task automatic finish_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      n_pass++;
      $display("test %s: PASS", name);
    end else begin
      n_fail++;
      $display("test %s: FAIL with %0d errors", name, err_cnt - errs_before);
    end
  endtask

  // 16-bit element at a byte address, little-endian within the word
  task automatic poke_elem(input logic [31:0] a, input logic [15:0] v);
    bank_mem[(a >> 2) % MP][(a >> 2) / MP][16*a[1] +: 16] = v;
  endtask

  function automatic logic [15:0] peek_elem(input logic [31:0] a);
    return bank_mem[(a >> 2) % MP][(a >> 2) / MP][16*a[1] +: 16];
  endfunction

  // one peripheral access; called right after a rising edge
  task automatic reg_access(input logic rd, input logic [7:0] off,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    logic [`MMUL_ID_W-1:0] id;
    id = next_id;
    next_id++;
    periph_req_i  <= 1'b1;
    periph_add_i  <= {24'd0, off};
    periph_wen_i  <= rd;
    periph_be_i   <= 4'hF;
    periph_data_i <= wdata;
    periph_id_i   <= id;
    @(posedge clk_i);
    if (periph_gnt_o !== 1'b1) report_mismatch("periph_gnt_o", periph_gnt_o, 1);
    if (periph_r_valid_o !== 1'b0) report_mismatch("periph_r_valid_o", periph_r_valid_o, 0);
    periph_req_i <= 1'b0;
    @(posedge clk_i);
    if (periph_r_valid_o !== 1'b1) report_mismatch("periph_r_valid_o", periph_r_valid_o, 1);
    if (periph_r_id_o !== id) report_mismatch("periph_r_id_o", periph_r_id_o, id);
    rdata = periph_r_data_o;
  endtask

  task automatic load_tests();
    int          fd;
    int          cnt;
    int          m;
    int          n;
    int          k;
    int          st;
    logic [31:0] xa;
    logic [31:0] wa;
    logic [31:0] za;
    logic [15:0] e;
    string       line;
    fd = $fopen("test/mmul_tests.txt", "r");
    if (fd == 0) begin
      report_problem("cannot open test/mmul_tests.txt");
      return;
    end
    line = "#";
    while (line.substr(0, 0) == "#" && !$feof(fd)) begin
      void'($fgets(line, fd));              // skip the column description
    end
    void'($sscanf(line, "%d", cnt));
    for (int t = 0; t < cnt; t++) begin
      void'($fscanf(fd, "%h %h %h %h %h %h %h", m, n, k, xa, wa, za, st));
      t_m.push_back(m);
      t_n.push_back(n);
      t_k.push_back(k);
      t_xa.push_back(xa);
      t_wa.push_back(wa);
      t_za.push_back(za);
      t_stall.push_back(st);
      t_base.push_back(vals.size());
      for (int i = 0; i < m*n + n*k + m*k; i++) begin
        void'($fscanf(fd, "%h", e));
        vals.push_back(e);
      end
      wd_cycles += 20*m*n*k/LANES + 200;
    end
    $fclose(fd);
  endtask

  task automatic check_registers();
    logic [7:0]  offs [6] = '{`MMUL_REG_X_ADDR, `MMUL_REG_W_ADDR, `MMUL_REG_Z_ADDR,
                             `MMUL_REG_M, `MMUL_REG_N, `MMUL_REG_K};
    logic [31:0] wvals [6] = '{32'h1234_5678, 32'h9abc_def0, 32'h0bad_f00d,
                              32'h0000_0011, 32'h0000_0022, 32'h0000_0c00};
    logic [31:0] rd;
    int          errs;
    errs = err_cnt;
    for (int i = 0; i < 6; i++) begin
      reg_access(1'b0, offs[i], wvals[i], rd);
    end
    for (int i = 0; i < 6; i++) begin
      reg_access(1'b1, offs[i], 32'd0, rd);
      if (rd !== wvals[i]) report_mismatch($sformatf("register 0x%h", offs[i]), rd, wvals[i]);
    end
    reg_access(1'b0, 8'h20, 32'hffff_ffff, rd);
    reg_access(1'b1, 8'h20, 32'd0, rd);
    if (rd !== 32'd0) report_mismatch("register 0x20", rd, 0);
    reg_access(1'b1, 8'hfc, 32'd0, rd);
    if (rd !== 32'd0) report_mismatch("register 0xfc", rd, 0);
    reg_access(1'b1, `MMUL_REG_STATUS, 32'd0, rd);
    if (rd !== 32'd0) report_mismatch("STATUS when idle", rd, 0);
    finish_test("registers", errs);
  endtask

  task automatic run_test(input int t);
    int          m;
    int          n;
    int          k;
    int          base;
    int          errs;
    int          cyc;
    int          evt_before;
    logic [31:0] rd;
    logic [15:0] got;
    m    = t_m[t];
    n    = t_n[t];
    k    = t_k[t];
    base = t_base[t];
    errs = err_cnt;
    for (int b = 0; b < MP; b++) begin
      for (int r = 0; r < DEPTH; r++) begin
        bank_mem[b][r] = 32'hA5C3_0000 ^ ((r*MP + b) * 4);   // fill tied to the byte address
      end
    end
    for (int i = 0; i < m*n; i++) poke_elem(t_xa[t] + 2*i, vals[base + i]);
    for (int i = 0; i < n*k; i++) poke_elem(t_wa[t] + 2*i, vals[base + m*n + i]);
    reg_access(1'b0, `MMUL_REG_X_ADDR, t_xa[t], rd);
    reg_access(1'b0, `MMUL_REG_W_ADDR, t_wa[t], rd);
    reg_access(1'b0, `MMUL_REG_Z_ADDR, t_za[t], rd);
    reg_access(1'b0, `MMUL_REG_M, m, rd);
    reg_access(1'b0, `MMUL_REG_N, n, rd);
    reg_access(1'b0, `MMUL_REG_K, k, rd);
    evt_before = evt_cnt;
    stall_en  <= t_stall[t][0];
    reg_access(1'b0, `MMUL_REG_TRIGGER, 32'd1, rd);
    reg_access(1'b1, `MMUL_REG_STATUS, 32'd0, rd);
    if (rd !== 32'd1) report_mismatch("STATUS while running", rd, 1);
    reg_access(1'b0, `MMUL_REG_M, 32'h0000_ffff, rd);     // must be dropped while busy
    reg_access(1'b0, `MMUL_REG_TRIGGER, 32'd1, rd);
    cyc = 0;
    while (evt_cnt == evt_before && cyc < 20*m*n*k/LANES + 200) begin
      @(posedge clk_i);
      cyc++;
    end
    if (evt_cnt == evt_before) report_problem($sformatf("test %0d never signalled completion", t));
    reg_access(1'b1, `MMUL_REG_STATUS, 32'd0, rd);
    if (rd !== 32'd0) report_mismatch("STATUS after run", rd, 0);
    reg_access(1'b1, `MMUL_REG_M, 32'd0, rd);
    if (rd !== m) report_mismatch("register M after run", rd, m);
    if (evt_cnt != evt_before + 1) report_mismatch("evt_o pulse count", evt_cnt - evt_before, 1);
    stall_en <= 1'b0;
    for (int i = 0; i < m*k; i++) begin
      got = peek_elem(t_za[t] + 2*i);
      if (got !== vals[base + m*n + n*k + i])
        report_mismatch($sformatf("Z[%0d][%0d]", i / k, i % k), got, vals[base + m*n + n*k + i]);
    end
    finish_test($sformatf("%0d", t + 1), errs);
  endtask

  // banked memory: grants per bank, read data one cycle after the grant
  initial begin : memory_model
    logic [MP-1:0]       wr_req;
    logic                store_open;
    logic [31:0]         held_addr;
    logic [MP-1:0][31:0] held_data;
    int                  row;
    store_open     = 1'b0;
    tcdm_gnt_i     = '0;
    tcdm_r_valid_i = '0;
    tcdm_r_data_i  = '0;
    void'($urandom(86582));
    forever begin
      @(posedge clk_i);
      wr_req = tcdm_req_o & ~tcdm_wen_o;
      if (store_open && !(wr_req == {MP{1'b1}} && tcdm_add_o[0] == held_addr &&
                          tcdm_data_o == held_data))
        report_problem("store dropped before every bank granted it");
      if (wr_req != '0 && wr_req != {MP{1'b1}}) report_problem("store issued on only some banks");
      store_open = (wr_req == {MP{1'b1}}) && ((tcdm_gnt_i & wr_req) != {MP{1'b1}});
      held_addr  = tcdm_add_o[0];
      held_data  = tcdm_data_o;
      for (int b = 0; b < MP; b++) begin
        if (tcdm_req_o[b] && tcdm_gnt_i[b]) begin
          row = (tcdm_add_o[b] >> 2) / MP;
          if (((tcdm_add_o[b] >> 2) % MP) != b) report_problem("port addressed a foreign bank");
          if (tcdm_be_o[b] !== 4'hF) report_mismatch("tcdm_be_o", tcdm_be_o[b], 4'hF);
          if (tcdm_wen_o[b]) tcdm_r_data_i[b] <= bank_mem[b][row];
          else bank_mem[b][row] <= tcdm_data_o[b];
          tcdm_r_valid_i[b] <= tcdm_wen_o[b];
        end else begin
          tcdm_r_valid_i[b] <= 1'b0;
        end
        tcdm_gnt_i[b] <= stall_en ? (($urandom % 4) != 0) : 1'b1;
      end
    end
  end

  // completion event must hit all cores in the cycle busy falls
  always @(posedge clk_i) begin
    if (arst_n_i) begin
      if (evt_o !== '0) begin
        evt_cnt++;
        if (evt_o !== {`MMUL_N_CORES{1'b1}}) report_mismatch("evt_o", evt_o, {`MMUL_N_CORES{1'b1}});
        if (!(busy_prev && !busy_o)) report_problem("evt_o pulsed outside the falling busy cycle");
      end else if (busy_prev && !busy_o) begin
        report_problem("busy_o fell without an evt_o pulse");
      end
      busy_prev = busy_o;
    end
  end

  initial begin : watchdog
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge clk_i);
    $display("ERROR: run exceeded %0d cycles, the DUT stopped making progress", wd_cycles);
    $display("Regression failed");
    $finish;
  end

  initial begin : main
    arst_n_i      = 1'b0;
    periph_req_i  = 1'b0;
    periph_add_i  = '0;
    periph_wen_i  = 1'b1;
    periph_be_i   = 4'h0;
    periph_data_i = '0;
    periph_id_i   = '0;
    stall_en      = 1'b0;
    next_id       = 8'h40;
    load_tests();
    repeat (16) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(posedge clk_i);
    check_registers();
    for (int t = 0; t < t_m.size(); t++) begin
      run_test(t);
    end
    $display("tests passed %0d, tests failed %0d, check errors %0d", n_pass, n_fail, err_cnt);
    if (err_cnt == 0 && n_fail == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+verilog
verilog/mmul_pkg.sv
verilog/mmul_regfile.sv
verilog/mmul_ctrl.sv
verilog/mmul_streamer.sv
verilog/mmul_datapath.sv
verilog/mmul_wrap.sv
test/tb_mmul.sv

//--- test/mmul_tests.txt
# per test: m n k x_addr w_addr z_addr stall (hex), then X, W and expected Z
# as row-major 16-bit hex elements; the first data line is the test count
4
1 2 4 000 040 080 0
0001 0002
0001 0002 0003 0004
0005 0006 0007 0008
000b 000e 0011 0014
2 2 4 100 140 180 0
7fff 0002 ffff 0003
0002 0001 ffff 0100
0001 4000 0005 0000
0000 ffff 800b ff00
0001 bfff 0010 ff00
2 2 4 200 240 280 1
7fff 0002 ffff 0003
0002 0001 ffff 0100
0001 4000 0005 0000
0000 ffff 800b ff00
0001 bfff 0010 ff00
1 3 8 300 320 3c0 1
0001 ffff 0002
0001 0002 0003 0004 0005 0006 0007 0008
0010 0020 0030 0040 0050 0060 0070 0080
0100 0200 0300 0400 0500 0600 0700 0800
01f1 03e2 05d3 07c4 09b5 0ba6 0d97 0f88
